//--- Makefile
VERILATOR ?= verilator
TOP       ?= deparser_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# a failing run stops on $fatal, so the binary exits non-zero
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/action_decode.sv
`timescale 1ns/1ps

module action_decode (
	input  logic                clk,
	input  logic                aresetn,
	input  deparse_pkg::entry_t rd_entry,
	output deparse_pkg::entry_t acts
);
	import deparse_pkg::*;

	entry_t checked;

	always_comb begin
		logic [4:0] end_pos;
		for (int i = 0; i < N_ACTIONS; i++) begin
			end_pos = {1'b0, rd_entry[i].offset} + {2'b00, ctype_bytes(rd_entry[i].ctype)};
			checked[i] = rd_entry[i];
			// field must fit inside the window
			checked[i].valid = rd_entry[i].valid && rd_entry[i].ctype != CT_NONE
				&& end_pos <= 5'(HDR_BYTES);
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			acts <= '0;
		else
			acts <= checked;
	end

endmodule

//--- logic/action_table.sv
`timescale 1ns/1ps

module action_table (
	input  logic                clk,
	input  logic                aresetn,
	input  deparse_pkg::beat_t  ctrl_beat,
	input  logic                ctrl_valid,
	input  logic [3:0]          rd_idx,
	output deparse_pkg::entry_t rd_entry
);
	import deparse_pkg::*;

	ctrl_state_e state;
	logic [3:0]  wr_addr;
	logic [63:0] swapped;
	logic        wr_en;
	entry_t      tbl [TABLE_DEPTH];

	// beat byte 0 lands in the top byte of the entry word
	always_comb begin
		for (int b = 0; b < DATA_BYTES; b++)
			swapped[8 * (DATA_BYTES - 1 - b) +: 8] = ctrl_beat.data[8 * b +: 8];
	end

	assign wr_en = ctrl_valid && state == CS_DATA;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= CS_HEAD;
			wr_addr <= '0;
		end else if (ctrl_valid) begin
			case (state)
				CS_HEAD: begin
					wr_addr <= ctrl_beat.data[11:8]; // low nibble of byte 1
					if (ctrl_beat.last)
						state <= CS_HEAD;
					else if (ctrl_beat.data[7:0] == DEPARSER_MOD_ID)
						state <= CS_DATA;
					else
						state <= CS_SKIP; // someone else's packet
				end
				CS_DATA: begin
					state <= ctrl_beat.last ? CS_HEAD : CS_SKIP;
				end
				default: begin
					if (ctrl_beat.last)
						state <= CS_HEAD;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < TABLE_DEPTH; i++)
				tbl[i] <= '0;
		end else if (wr_en) begin
			tbl[wr_addr] <= entry_t'(swapped[$bits(entry_t)-1:0]);
		end
	end

	always_ff @(posedge clk) begin
		rd_entry <= tbl[rd_idx];
	end

	// a control packet is at least a head and a data beat
	assert property (@(posedge clk) disable iff (!aresetn)
		ctrl_valid && state == CS_HEAD |-> !ctrl_beat.last);

endmodule

//--- logic/deparse_pkg.sv
package deparse_pkg;

	localparam int DATA_BYTES  = 8;
	localparam int HDR_BEATS   = 2;
	localparam int HDR_BYTES   = HDR_BEATS * DATA_BYTES;
	localparam int N_ACTIONS   = 4;
	localparam int ACT_W       = $clog2(N_ACTIONS);
	localparam int N_CONT      = 4;
	localparam int TABLE_DEPTH = 16;
	localparam logic [7:0] DEPARSER_MOD_ID = 8'd5;

	typedef enum logic [1:0] {CT_NONE, CT_2B, CT_4B, CT_6B} ctype_e;

	typedef struct packed {
		logic [8*DATA_BYTES-1:0] data;
		logic [DATA_BYTES-1:0]   keep;
		logic                    last;
	} beat_t;

	typedef struct packed {
		logic       valid;
		logic [3:0] offset; // first byte in the window
		ctype_e     ctype;
		logic [1:0] cidx;
	} act_t;

	typedef act_t [N_ACTIONS-1:0] entry_t;

	typedef struct packed {
		logic                    discard;
		logic [3:0]              table_idx;
		logic [N_CONT-1:0][15:0] c2;
		logic [N_CONT-1:0][31:0] c4;
		logic [N_CONT-1:0][47:0] c6;
	} phv_t;

	typedef enum logic [2:0] {
		ST_IDLE, ST_HDR1, ST_LOOKUP, ST_EDIT, ST_EMIT0, ST_EMIT1, ST_PASS, ST_DROP
	} emit_state_e;

	typedef enum logic [1:0] {CS_HEAD, CS_DATA, CS_SKIP} ctrl_state_e;

	// container size in bytes
	function automatic logic [2:0] ctype_bytes(ctype_e t);
		case (t)
			CT_2B:   return 3'd2;
			CT_4B:   return 3'd4;
			CT_6B:   return 3'd6;
			default: return 3'd0;
		endcase
	endfunction

endpackage

//--- logic/deparser_top.sv
`timescale 1ns/1ps

module deparser_top (
	input  logic               clk,
	input  logic               aresetn,
	input  deparse_pkg::beat_t pkt_beat,
	input  logic               pkt_empty,
	output logic               pkt_rd_en,
	input  deparse_pkg::phv_t  phv,
	input  logic               phv_empty,
	output logic               phv_rd_en,
	input  deparse_pkg::beat_t ctrl_beat,
	input  logic               ctrl_valid,
	output deparse_pkg::beat_t out_beat,
	output logic               out_valid,
	input  logic               out_ready
);
	import deparse_pkg::*;

	entry_t                rd_entry;
	entry_t                acts;
	beat_t                 hdr_beat;
	beat_t [HDR_BEATS-1:0] hdr_out;
	logic                  hdr_load;
	logic                  hdr_slot;
	logic                  edit_start;
	logic                  edit_done;

	// lookup runs off the phv fifo head
	action_table u_table (
		.clk        (clk),
		.aresetn    (aresetn),
		.ctrl_beat  (ctrl_beat),
		.ctrl_valid (ctrl_valid),
		.rd_idx     (phv.table_idx),
		.rd_entry   (rd_entry)
	);

	action_decode u_decode (
		.clk      (clk),
		.aresetn  (aresetn),
		.rd_entry (rd_entry),
		.acts     (acts)
	);

	field_writer u_writer (
		.clk        (clk),
		.aresetn    (aresetn),
		.hdr_load   (hdr_load),
		.hdr_slot   (hdr_slot),
		.hdr_beat   (hdr_beat),
		.edit_start (edit_start),
		.acts       (acts),
		.phv        (phv),
		.hdr_out    (hdr_out),
		.edit_done  (edit_done)
	);

	packet_emitter u_emitter (
		.clk         (clk),
		.aresetn     (aresetn),
		.pkt_beat    (pkt_beat),
		.pkt_empty   (pkt_empty),
		.phv_empty   (phv_empty),
		.phv_discard (phv.discard),
		.hdr_out     (hdr_out),
		.edit_done   (edit_done),
		.out_ready   (out_ready),
		.pkt_rd_en   (pkt_rd_en),
		.phv_rd_en   (phv_rd_en),
		.hdr_load    (hdr_load),
		.hdr_slot    (hdr_slot),
		.hdr_beat    (hdr_beat),
		.edit_start  (edit_start),
		.out_beat    (out_beat),
		.out_valid   (out_valid)
	);

endmodule

//--- logic/field_writer.sv
`timescale 1ns/1ps

module field_writer (
	input  logic                                           clk,
	input  logic                                           aresetn,
	input  logic                                           hdr_load,
	input  logic                                           hdr_slot,
	input  deparse_pkg::beat_t                             hdr_beat,
	input  logic                                           edit_start,
	input  deparse_pkg::entry_t                            acts,
	input  deparse_pkg::phv_t                              phv,
	output deparse_pkg::beat_t [deparse_pkg::HDR_BEATS-1:0] hdr_out,
	output logic                                           edit_done
);
	import deparse_pkg::*;

	logic                      busy;
	logic [ACT_W-1:0]          cnt;
	act_t                      cur;
	logic [2:0]                nbytes;
	logic [47:0]               val;
	logic [HDR_BYTES-1:0]      hit;
	logic [HDR_BYTES-1:0][7:0] src;

	assign cur = acts[cnt]; // one action per cycle
	assign nbytes = ctype_bytes(cur.ctype);
	assign edit_done = busy && cnt == ACT_W'(N_ACTIONS - 1);

	always_comb begin
		case (cur.ctype)
			CT_2B:   val = {32'd0, phv.c2[cur.cidx]};
			CT_4B:   val = {16'd0, phv.c4[cur.cidx]};
			CT_6B:   val = phv.c6[cur.cidx];
			default: val = '0;
		endcase
	end

	// window byte k gets field byte k - offset, msb first
	always_comb begin
		int rel;
		for (int k = 0; k < HDR_BYTES; k++) begin
			rel = k - int'(cur.offset);
			hit[k] = busy && cur.valid && rel >= 0 && rel < int'(nbytes);
			if (hit[k])
				src[k] = val[8 * (int'(nbytes) - 1 - rel) +: 8];
			else
				src[k] = 8'h00;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (edit_start) begin
			busy <= 1'b1;
			cnt <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (edit_done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (hdr_load) begin
			hdr_out[hdr_slot] <= hdr_beat;
		end else begin
			for (int k = 0; k < HDR_BYTES; k++)
				if (hit[k])
					hdr_out[k / DATA_BYTES].data[8 * (k % DATA_BYTES) +: 8] <= src[k];
		end
	end

	assert property (@(posedge clk) disable iff (!aresetn) edit_start |-> !busy);

endmodule

//--- logic/packet_emitter.sv
`timescale 1ns/1ps

module packet_emitter (
	input  logic                                           clk,
	input  logic                                           aresetn,
	input  deparse_pkg::beat_t                             pkt_beat,
	input  logic                                           pkt_empty,
	input  logic                                           phv_empty,
	input  logic                                           phv_discard,
	input  deparse_pkg::beat_t [deparse_pkg::HDR_BEATS-1:0] hdr_out,
	input  logic                                           edit_done,
	input  logic                                           out_ready,
	output logic                                           pkt_rd_en,
	output logic                                           phv_rd_en,
	output logic                                           hdr_load,
	output logic                                           hdr_slot,
	output deparse_pkg::beat_t                             hdr_beat,
	output logic                                           edit_start,
	output deparse_pkg::beat_t                             out_beat,
	output logic                                           out_valid
);
	import deparse_pkg::*;

	emit_state_e state, state_next;

	assign hdr_beat = pkt_beat;
	assign hdr_slot = (state == ST_HDR1);
	assign edit_start = (state == ST_LOOKUP); // table entry settles here

	always_comb begin
		state_next = state;
		pkt_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		hdr_load = 1'b0;
		out_valid = 1'b0;
		out_beat = pkt_beat;
		case (state)
			ST_IDLE: begin
				if (!pkt_empty && !phv_empty) begin
					pkt_rd_en = 1'b1;
					hdr_load = 1'b1;
					if (phv_discard) begin
						phv_rd_en = 1'b1;
						state_next = pkt_beat.last ? ST_IDLE : ST_DROP;
					end else begin
						state_next = pkt_beat.last ? ST_LOOKUP : ST_HDR1;
					end
				end
			end
			ST_HDR1: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					hdr_load = 1'b1;
					state_next = ST_LOOKUP;
				end
			end
			ST_LOOKUP: begin
				state_next = ST_EDIT;
			end
			ST_EDIT: begin
				if (edit_done)
					state_next = ST_EMIT0;
			end
			ST_EMIT0: begin
				out_valid = 1'b1;
				out_beat = hdr_out[0];
				if (out_ready) begin
					if (hdr_out[0].last) begin
						phv_rd_en = 1'b1; // single beat packet
						state_next = ST_IDLE;
					end else begin
						state_next = ST_EMIT1;
					end
				end
			end
			ST_EMIT1: begin
				out_valid = 1'b1;
				out_beat = hdr_out[1];
				if (out_ready) begin
					phv_rd_en = 1'b1;
					state_next = hdr_out[1].last ? ST_IDLE : ST_PASS;
				end
			end
			ST_PASS: begin
				out_valid = !pkt_empty;
				pkt_rd_en = !pkt_empty && out_ready;
				if (pkt_rd_en && pkt_beat.last)
					state_next = ST_IDLE;
			end
			ST_DROP: begin
				pkt_rd_en = !pkt_empty;
				if (pkt_rd_en && pkt_beat.last)
					state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	// holds across emit and pass states alike
	assert property (@(posedge clk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

//--- tb.f
logic/deparse_pkg.sv
logic/action_table.sv
logic/action_decode.sv
logic/field_writer.sv
logic/packet_emitter.sv
logic/deparser_top.sv
tests/deparser_tb.sv

//--- tests/deparser_tb.sv
`timescale 1ns/1ps

module deparser_tb;
	import deparse_pkg::*;

	localparam int HALF = 4;
	localparam int MAX_CYCLES = 3000;
	localparam int DRAIN_CYCLES = 16; // idle cycles that must stay silent at the end
	localparam int MAX_RECORDS = 64;

	logic  clk;
	logic  aresetn;
	beat_t pkt_beat;
	logic  pkt_empty;
	logic  pkt_rd_en;
	phv_t  phv;
	logic  phv_empty;
	logic  phv_rd_en;
	beat_t ctrl_beat;
	logic  ctrl_valid;
	beat_t out_beat;
	logic  out_valid;
	logic  out_ready;

	logic [79:0] rec [MAX_RECORDS];
	beat_t       ctrl_q[$];
	beat_t       pkt_q[$];
	beat_t       exp_q[$];
	phv_t        phv_q[$];
	logic [15:0] lfsr;

	deparser_top uut (
		.clk        (clk),
		.aresetn    (aresetn),
		.pkt_beat   (pkt_beat),
		.pkt_empty  (pkt_empty),
		.pkt_rd_en  (pkt_rd_en),
		.phv        (phv),
		.phv_empty  (phv_empty),
		.phv_rd_en  (phv_rd_en),
		.ctrl_beat  (ctrl_beat),
		.ctrl_valid (ctrl_valid),
		.out_beat   (out_beat),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

	always #HALF clk = ~clk;

	// galois form, one step per bit
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	task automatic stop_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped on first error");
	endtask

	task automatic check_beat(input beat_t got, input beat_t exp);
		if (got !== exp) begin
			$display("ERROR out_beat got data=%h keep=%h last=%h",
				got.data, got.keep, got.last);
			$display("ERROR out_beat exp data=%h keep=%h last=%h",
				exp.data, exp.keep, exp.last);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic load_testdata();
		phv_t       cur;
		beat_t      b;
		logic [3:0] op;
		logic [3:0] aux;
		logic [7:0] col;
		bit         at_end;
		cur = '0; // containers carry over between pushes
		at_end = 1'b0;
		$readmemh("tests/deparser_testdata.hex", rec);
		for (int i = 0; i < MAX_RECORDS && !at_end; i++) begin
			op = rec[i][79:76];
			aux = rec[i][75:72];
			col = rec[i][71:64];
			b.data = rec[i][63:0];
			b.keep = col;
			b.last = aux[0];
			case (op)
				4'h1: ctrl_q.push_back(b);
				4'h2: pkt_q.push_back(b);
				4'h3: exp_q.push_back(b);
				4'h4: begin
					case (aux)
						4'h1: cur.c2[col[1:0]] = rec[i][15:0];
						4'h2: cur.c4[col[1:0]] = rec[i][31:0];
						4'h3: cur.c6[col[1:0]] = rec[i][47:0];
						default: begin
							$display("bad container size in test data record %0d", i);
							stop_run();
						end
					endcase
				end
				4'h5: begin
					cur.discard = aux[0];
					cur.table_idx = col[3:0];
					phv_q.push_back(cur);
				end
				4'hF: at_end = 1'b1;
				default: begin
					$display("unknown opcode %h in test data record %0d", op, i);
					stop_run();
				end
			endcase
		end
		if (!at_end || exp_q.size() == 0) begin
			$display("test data file is incomplete or holds no expected beats");
			stop_run();
		end
	endtask

	// fifo heads shown while not empty
	task automatic drive_fifos();
		pkt_empty = (pkt_q.size() == 0);
		phv_empty = (phv_q.size() == 0);
		if (pkt_empty)
			pkt_beat = '0;
		else
			pkt_beat = pkt_q[0];
		if (phv_empty)
			phv = '0;
		else
			phv = phv_q[0];
	endtask

	task automatic sample_outputs();
		if (out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("extra output beat with data %h after all expected beats",
					out_beat.data);
				stop_run();
			end else begin
				check_beat(out_beat, exp_q.pop_front());
			end
		end
		if (pkt_rd_en) begin
			if (pkt_q.size() == 0) begin
				$display("packet FIFO was read while empty");
				stop_run();
			end else begin
				void'(pkt_q.pop_front());
			end
		end
		if (phv_rd_en) begin
			if (phv_q.size() == 0) begin
				$display("PHV FIFO was read while empty");
				stop_run();
			end else begin
				void'(phv_q.pop_front());
			end
		end
	endtask

	initial begin
		int cycles;
		int quiet;
		bit finished;
		clk = 1'b0;
		aresetn = 1'b0;
		pkt_beat = '0;
		pkt_empty = 1'b1;
		phv = '0;
		phv_empty = 1'b1;
		ctrl_beat = '0;
		ctrl_valid = 1'b0;
		out_ready = 1'b0;
		lfsr = 16'd40;
		cycles = 0;
		quiet = 0;
		finished = 1'b0;
		load_testdata();

		repeat (8) @(negedge clk);
		aresetn = 1'b1;
		#1;
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("pkt_rd_en", pkt_rd_en, 1'b0);
		check_flag("phv_rd_en", phv_rd_en, 1'b0);

		// table is programmed before any packet shows up
		foreach (ctrl_q[i]) begin
			@(negedge clk);
			ctrl_beat = ctrl_q[i];
			ctrl_valid = 1'b1;
		end
		@(negedge clk);
		ctrl_beat = '0;
		ctrl_valid = 1'b0;
		repeat (2) @(negedge clk);

		while (!finished && cycles < MAX_CYCLES) begin
			@(negedge clk);
			lfsr = lfsr_step(lfsr);
			out_ready = lfsr[0];
			drive_fifos();
			#(HALF - 1); // just before the rising edge
			sample_outputs();
			if (pkt_q.size() == 0 && phv_q.size() == 0 && exp_q.size() == 0)
				quiet++;
			else
				quiet = 0;
			finished = (quiet >= DRAIN_CYCLES);
			cycles++;
		end

		if (finished) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("timed out after %0d cycles with %0d expected beats not seen",
				cycles, exp_q.size());
			stop_run();
		end
	end

endmodule

//--- tests/deparser_testdata.hex
// op aux keep data: op 1 control beat, 2 packet beat, 3 expected beat (aux = last)
// op 4 container (aux 1/2/3 = c2/c4/c6, keep column = index), 5 push phv (aux = discard, keep column = table), f end
1_0_FF_0000000000000105 // head, table 1
1_1_FF_16BB2E2709000000
1_0_FF_0000000000000205 // head, table 2
1_1_FF_D861326A08000000
1_0_FF_0000000000000206 // module 6, skipped
1_0_FF_0000000000000205
1_1_FF_0401000000000000
4_1_02_000000000000A1B2
4_1_00_000000000000C3D4
4_2_03_00000000DEADBEEF
4_3_01_0000112233445566
5_0_01_0000000000000000 // packet 1 on table 1
2_0_FF_0706050403020100
2_0_FF_0F0E0D0C0B0A0908
2_1_0F_5555555500C0FFEE
3_0_FF_33221104D4C3A100
3_0_FF_EFBEADDE0B665544
3_1_0F_5555555500C0FFEE
5_1_01_0000000000000000 // packet 2 discarded
2_0_FF_AAAAAAAAAAAAAAAA
2_1_FF_BBBBBBBBBBBBBBBB
5_0_02_0000000000000000 // packet 3, only one action survives decode
2_0_FF_8786858483828180
2_1_7F_008E8D8C8B8A8988
3_0_FF_8786665544332211
3_1_7F_008E8D8C8B8A8988
5_0_01_0000000000000000 // packet 4, single beat
2_1_3F_F7F6F5F4F3F2F1F0
3_1_3F_332211F4D4C3A1F0
F_0_00_0000000000000000
